//--- ps2_host.f
+incdir+design
design/ps2_pkg.sv
design/ps2_line_if.sv
design/ps2_clock_filter.sv
design/ps2_receiver.sv
design/ps2_transmitter.sv
design/ps2_host.sv
verification/tb_ps2_host.sv

//--- Bender.yml
package:
  name: ps2_host

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ps2_pkg.sv
      - design/ps2_line_if.sv
      - design/ps2_clock_filter.sv
      - design/ps2_receiver.sv
      - design/ps2_transmitter.sv
      - design/ps2_host.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/tb_ps2_host.sv

//--- verification/tb_ps2_host.sv
// Directed testbench for the PS/2 host port with a bus-level device model

`timescale 1ns/1ps

`include "ps2_consts.svh"

module tb_ps2_host;

    import ps2_pkg::*;

    // Device clock half period in system cycles
    localparam int HALF       = 40;
    localparam int PERIOD_NS  = 20;
    // Six device frames and six host frames
    localparam int NUM_FRAMES = 12;
    // Six sends plus the quiet window of two inhibit lengths
    localparam int NUM_INHIBITS = 8;
    localparam int WATCHDOG_NS  = 2 * (NUM_FRAMES * `PS2_FRAME_BITS * 2 * HALF * PERIOD_NS
                                  + NUM_INHIBITS * `PS2_INHIBIT_CYCLES * PERIOD_NS);

    logic      clock_i;
    logic      reset_i;
    logic      tx_valid_i;
    ps2_byte_t tx_data_i;
    logic      tx_ready_o;
    logic      tx_ack_error_o;
    logic      rx_valid_o;
    logic      rx_error_o;
    ps2_byte_t rx_data_o;
    logic      ps2_clk_oe_o;
    logic      ps2_data_oe_o;
    logic      ps2_clk_i;
    logic      ps2_data_i;

    // Device side pull-downs
    logic dev_clk_low;
    logic dev_data_low;

    int          errors;
    int          valid_cnt;
    int          error_cnt;
    int          ack_cnt;
    ps2_byte_t   last_good;
    logic [31:0] lcg_state;

    // Open-drain bus stays high unless someone pulls low
    assign ps2_clk_i  = ~(ps2_clk_oe_o | dev_clk_low);
    assign ps2_data_i = ~(ps2_data_oe_o | dev_data_low);

    ps2_host u_ps2_host (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .ps2_clk_i      (ps2_clk_i),
        .ps2_data_i     (ps2_data_i),
        .ps2_clk_oe_o   (ps2_clk_oe_o),
        .ps2_data_oe_o  (ps2_data_oe_o),
        .tx_valid_i     (tx_valid_i),
        .tx_data_i      (tx_data_i),
        .tx_ready_o     (tx_ready_o),
        .tx_ack_error_o (tx_ack_error_o),
        .rx_valid_o     (rx_valid_o),
        .rx_error_o     (rx_error_o),
        .rx_data_o      (rx_data_o)
    );

    initial begin
        clock_i = 1'b0;
        forever #10 clock_i = ~clock_i;
    end

    // Registered outputs read at the edge hold last cycle's value
    always @(posedge clock_i) begin
        if (!reset_i) begin
            valid_cnt <= valid_cnt + rx_valid_o;
            error_cnt <= error_cnt + rx_error_o;
            ack_cnt   <= ack_cnt + tx_ack_error_o;
        end
    end

    // ------------------------------------------------------------
    // Helpers and compares
    // ------------------------------------------------------------
    function automatic ps2_byte_t lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // Parity bit that makes the count of ones over data and parity odd
    function automatic logic odd_parity_bit(input ps2_byte_t value);
        return ($countones(value) % 2) == 0;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clock_i);
    endtask

    task automatic check_byte(input string name, input ps2_byte_t expected,
                              input ps2_byte_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // Device to host frame
    // ------------------------------------------------------------
    task automatic device_send(input ps2_byte_t value, input logic bad_parity,
                               input logic bad_stop);
        logic [11:0] frame;
        logic        good;
        int          valid_before;
        int          error_before;
        good         = !bad_parity && !bad_stop;
        valid_before = valid_cnt;
        error_before = error_cnt;
        // Extra one on top leaves the line released after the stop bit
        frame        = {1'b1, ~bad_stop, odd_parity_bit(value) ^ bad_parity, value, 1'b0};
        dev_data_low = ~frame[0];
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            wait_cycles(HALF);
            dev_clk_low = 1'b1;
            // Next bit goes out mid low phase after the host sample
            wait_cycles(HALF / 2);
            dev_data_low = ~frame[i + 1];
            wait_cycles(HALF / 2);
            dev_clk_low = 1'b0;
        end
        wait_cycles(HALF);
        check_count("rx_valid_o pulses", good ? 1 : 0, valid_cnt - valid_before);
        check_count("rx_error_o pulses", good ? 0 : 1, error_cnt - error_before);
        if (good) begin
            last_good = value;
        end
        check_byte("rx_data_o", last_good, rx_data_o);
    endtask

    // ------------------------------------------------------------
    // Host to device frame
    // ------------------------------------------------------------
    task automatic host_send(input ps2_byte_t value, input logic give_ack);
        int         hold;
        int         acks_before;
        logic [9:0] bits;
        logic       start_bit;
        hold        = 0;
        acks_before = ack_cnt;
        @(negedge clock_i);
        tx_valid_i = 1'b1;
        tx_data_i  = value;
        while (!tx_ready_o) @(negedge clock_i);
        // Taken on the edge in between
        @(negedge clock_i);
        tx_valid_i = 1'b0;
        while (ps2_clk_oe_o) begin
            hold++;
            @(negedge clock_i);
        end
        check_count("ps2_clk_oe_o hold cycles", `PS2_INHIBIT_CYCLES, hold);
        start_bit = ps2_data_i;
        // Host changes data after each fall and the device reads on the rise
        for (int i = 0; i < `PS2_FRAME_BITS - 1; i++) begin
            wait_cycles(HALF);
            dev_clk_low = 1'b1;
            wait_cycles(HALF);
            dev_clk_low = 1'b0;
            bits[i] = ps2_data_i;
        end
        // Eleventh pulse carries the acknowledge
        wait_cycles(HALF / 2);
        dev_data_low = give_ack;
        wait_cycles(HALF / 2);
        dev_clk_low = 1'b1;
        wait_cycles(HALF);
        dev_clk_low  = 1'b0;
        dev_data_low = 1'b0;
        while (!tx_ready_o) @(negedge clock_i);
        wait_cycles(HALF);
        check_flag("start bit", 1'b0, start_bit);
        check_byte("device byte", value, bits[7:0]);
        check_flag("parity bit", odd_parity_bit(value), bits[8]);
        check_flag("stop bit", 1'b1, bits[9]);
        check_count("tx_ack_error_o pulses", give_ack ? 0 : 1, ack_cnt - acks_before);
        check_flag("tx_ready_o", 1'b1, tx_ready_o);
    endtask

    // Offers a byte only while the transmitter is busy
    task automatic present_while_busy(input ps2_byte_t value);
        @(negedge clock_i);
        while (tx_ready_o) @(negedge clock_i);
        wait_cycles(10);
        tx_valid_i = 1'b1;
        tx_data_i  = value;
        wait_cycles(100);
        check_flag("tx_ready_o while busy", 1'b0, tx_ready_o);
        tx_valid_i = 1'b0;
    endtask

    // No send may start with nothing offered
    task automatic check_bus_quiet(input int cycles);
        int pulled;
        pulled = 0;
        repeat (cycles) begin
            @(negedge clock_i);
            pulled += ps2_clk_oe_o;
        end
        check_count("ps2_clk_oe_o cycles while idle", 0, pulled);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        ps2_byte_t first;
        ps2_byte_t second;
        reset_i      = 1'b1;
        tx_valid_i   = 1'b0;
        tx_data_i    = '0;
        dev_clk_low  = 1'b0;
        dev_data_low = 1'b0;
        errors       = 0;
        valid_cnt    = 0;
        error_cnt    = 0;
        ack_cnt      = 0;
        last_good    = '0;
        lcg_state    = 32'h176f_99a1;
        wait_cycles(4);
        reset_i = 1'b0;
        wait_cycles(2);

        check_flag("tx_ready_o", 1'b1, tx_ready_o);
        check_flag("ps2_clk_oe_o", 1'b0, ps2_clk_oe_o);
        check_flag("ps2_data_oe_o", 1'b0, ps2_data_oe_o);
        check_flag("rx_valid_o", 1'b0, rx_valid_o);
        check_flag("rx_error_o", 1'b0, rx_error_o);

        repeat (4) device_send(lcg_byte(), 1'b0, 1'b0);
        device_send(lcg_byte(), 1'b1, 1'b0);
        device_send(lcg_byte(), 1'b0, 1'b1);

        repeat (3) host_send(lcg_byte(), 1'b1);
        host_send(lcg_byte(), 1'b0);

        // Second byte offered during a send must wait its turn
        first  = lcg_byte();
        second = lcg_byte();
        fork
            host_send(first, 1'b1);
            present_while_busy(second);
        join
        check_bus_quiet(2 * `PS2_INHIBIT_CYCLES);
        host_send(second, 1'b1);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- design/ps2_host.sv
// PS/2 host port top level with open-drain enables for clock and data

`timescale 1ns/1ps

module ps2_host (
    input  logic               clock_i,
    input  logic               reset_i,
    // Bus lines as seen at the pads
    input  logic               ps2_clk_i,
    input  logic               ps2_data_i,
    output logic               ps2_clk_oe_o,
    output logic               ps2_data_oe_o,
    // Send side
    input  logic               tx_valid_i,
    input  ps2_pkg::ps2_byte_t tx_data_i,
    output logic               tx_ready_o,
    output logic               tx_ack_error_o,
    // Receive side
    output logic               rx_valid_o,
    output logic               rx_error_o,
    output ps2_pkg::ps2_byte_t rx_data_o
);

    logic tx_active;

    ps2_line_if u_line ();

    ps2_clock_filter u_filter (
        .clock_i    (clock_i),
        .reset_i    (reset_i),
        .ps2_clk_i  (ps2_clk_i),
        .ps2_data_i (ps2_data_i),
        .line       (u_line.filter)
    );

    // Receiver stays quiet while the host drives the bus
    ps2_receiver u_receiver (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .tx_active_i (tx_active),
        .line        (u_line.receiver),
        .rx_valid_o  (rx_valid_o),
        .rx_error_o  (rx_error_o),
        .rx_data_o   (rx_data_o)
    );

    ps2_transmitter u_transmitter (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .tx_valid_i     (tx_valid_i),
        .tx_data_i      (tx_data_i),
        .tx_ready_o     (tx_ready_o),
        .tx_active_o    (tx_active),
        .tx_ack_error_o (tx_ack_error_o),
        .line           (u_line.transmitter)
    );

    // Pull requests drive the pad enables, pads tie low
    assign ps2_clk_oe_o  = u_line.clk_pull;
    assign ps2_data_oe_o = u_line.data_pull;

endmodule

//--- design/ps2_transmitter.sv
// PS/2 host-to-device sender with clock inhibit, bit shift and acknowledge check

`timescale 1ns/1ps

`include "ps2_consts.svh"

module ps2_transmitter (
    input  logic               clock_i,
    input  logic               reset_i,
    input  logic               tx_valid_i,
    input  ps2_pkg::ps2_byte_t tx_data_i,
    output logic               tx_ready_o,
    output logic               tx_active_o,
    output logic               tx_ack_error_o,
    ps2_line_if.transmitter    line
);

    import ps2_pkg::*;

    localparam int INHIB_W = $clog2(`PS2_INHIBIT_CYCLES);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INHIBIT,
        ST_REQUEST,
        ST_SHIFT,
        ST_ACK
    } tx_state_t;

    tx_state_t            state;
    logic [INHIB_W-1:0]   inhibit_cnt;
    ps2_bit_count_t       bit_cnt;
    // Stop, parity, data, start with the current bit at index 0
    logic [`PS2_FRAME_BITS-1:0] frame_q;

    logic accept;

    assign accept      = tx_valid_i && tx_ready_o;
    assign tx_ready_o  = (state == ST_IDLE);
    assign tx_active_o = ~tx_ready_o;

    // ------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clock_i or posedge reset_i) begin
        if (reset_i) begin
            state          <= ST_IDLE;
            inhibit_cnt    <= '0;
            bit_cnt        <= '0;
            tx_ack_error_o <= 1'b0;
        end else begin
            tx_ack_error_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state       <= ST_INHIBIT;
                        inhibit_cnt <= '0;
                        bit_cnt     <= '0;
                    end
                end
                // Inhibit plus the one request cycle give the full hold time
                ST_INHIBIT: begin
                    inhibit_cnt <= inhibit_cnt + 1'b1;
                    if (inhibit_cnt == INHIB_W'(`PS2_INHIBIT_CYCLES - 2)) begin
                        state <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    state <= ST_SHIFT;
                end
                // Ten falls put out data, parity and stop
                ST_SHIFT: begin
                    if (line.clk_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == ps2_bit_count_t'(`PS2_FRAME_BITS - 2)) begin
                            state <= ST_ACK;
                        end
                    end
                end
                ST_ACK: begin
                    if (bit_cnt == ps2_bit_count_t'(`PS2_FRAME_BITS)) begin
                        state <= ST_IDLE;
                    end else if (line.clk_fall) begin
                        // Device answers with data low
                        tx_ack_error_o <= line.data_level;
                        bit_cnt        <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Frame register, loaded on acceptance and shifted on each clock fall
    always_ff @(posedge clock_i) begin
        if (accept) begin
            frame_q <= {1'b1, ~^tx_data_i, tx_data_i, 1'b0};
        end else if (state == ST_SHIFT && line.clk_fall) begin
            frame_q <= {1'b1, frame_q[`PS2_FRAME_BITS-1:1]};
        end
    end

    // ------------------------------------------------------------
    // Open-drain requests
    // ------------------------------------------------------------
    assign line.clk_pull  = (state == ST_INHIBIT) || (state == ST_REQUEST);
    // A one on the wire means let the line float
    assign line.data_pull = ((state == ST_REQUEST) || (state == ST_SHIFT)) && !frame_q[0];

    a_idle_released : assert property (
        @(posedge clock_i) disable iff (reset_i)
            tx_ready_o |-> (!line.clk_pull && !line.data_pull)
    );

endmodule

//--- design/ps2_receiver.sv
// PS/2 device-to-host frame receiver with odd parity and stop checks

`timescale 1ns/1ps

`include "ps2_consts.svh"

module ps2_receiver (
    input  logic              clock_i,
    input  logic              reset_i,
    input  logic              tx_active_i,
    ps2_line_if.receiver      line,
    output logic              rx_valid_o,
    output logic              rx_error_o,
    output ps2_pkg::ps2_byte_t rx_data_o
);

    import ps2_pkg::*;

    // Zero means idle and waiting for a start bit
    ps2_bit_count_t bit_cnt;
    // XOR of data and parity ends at 1 on a good frame
    logic           parity_acc;
    ps2_byte_t      shift_q;

    logic in_data;
    logic at_stop;

    assign in_data = (bit_cnt != '0) && (bit_cnt <= ps2_bit_count_t'(`PS2_DATA_BITS));
    assign at_stop = (bit_cnt == ps2_bit_count_t'(`PS2_FRAME_BITS - 1));

    // ------------------------------------------------------------
    // Frame control
    // ------------------------------------------------------------
    always_ff @(posedge clock_i or posedge reset_i) begin
        if (reset_i) begin
            bit_cnt    <= '0;
            parity_acc <= 1'b0;
            rx_valid_o <= 1'b0;
            rx_error_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            rx_error_o <= 1'b0;
            if (tx_active_i) begin
                // Host owns the bus so a partial frame is dropped
                bit_cnt <= '0;
            end else if (line.clk_fall) begin
                if (bit_cnt == '0) begin
                    if (!line.data_level) begin
                        bit_cnt    <= 4'd1;
                        parity_acc <= 1'b0;
                    end
                end else if (at_stop) begin
                    // Judge parity and stop bit together
                    if (parity_acc && line.data_level) begin
                        rx_valid_o <= 1'b1;
                    end else begin
                        rx_error_o <= 1'b1;
                    end
                    bit_cnt <= '0;
                end else begin
                    parity_acc <= parity_acc ^ line.data_level;
                    bit_cnt    <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clock_i) begin
        if (line.clk_fall && in_data) begin
            shift_q <= {line.data_level, shift_q[`PS2_DATA_BITS-1:1]};
        end
    end

    // Output byte only moves on a good frame
    always_ff @(posedge clock_i) begin
        if (line.clk_fall && at_stop && parity_acc && line.data_level && !tx_active_i) begin
            rx_data_o <= shift_q;
        end
    end

    a_one_result : assert property (
        @(posedge clock_i) disable iff (reset_i) !(rx_valid_o && rx_error_o)
    );

endmodule

//--- design/ps2_clock_filter.sv
// PS/2 line synchronizer and clock debouncer with falling-edge strobe

`timescale 1ns/1ps

`include "ps2_consts.svh"

module ps2_clock_filter (
    input  logic clock_i,
    input  logic reset_i,
    input  logic ps2_clk_i,
    input  logic ps2_data_i,
    ps2_line_if.filter line
);

    localparam int CNT_W = $clog2(`PS2_FILTER_CYCLES);

    // Two-flop synchronizers, idle bus is high
    logic [1:0] clk_sync;
    logic [1:0] data_sync;

    // Debounce state
    logic [CNT_W-1:0] diff_cnt;
    logic             clk_level;
    logic             clk_level_q;
    logic             clk_fall;

    always_ff @(posedge clock_i or posedge reset_i) begin
        if (reset_i) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk_i};
            data_sync <= {data_sync[0], ps2_data_i};
        end
    end

    // ------------------------------------------------------------
    // Level acceptance
    // ------------------------------------------------------------
    // A sample equal to the accepted level restarts the count
    always_ff @(posedge clock_i or posedge reset_i) begin
        if (reset_i) begin
            diff_cnt    <= '0;
            clk_level   <= 1'b1;
            clk_level_q <= 1'b1;
            clk_fall    <= 1'b0;
        end else begin
            clk_level_q <= clk_level;
            // Strobe one cycle after the level drops
            clk_fall    <= clk_level_q & ~clk_level;
            if (clk_sync[1] == clk_level) begin
                diff_cnt <= '0;
            end else if (diff_cnt == CNT_W'(`PS2_FILTER_CYCLES - 1)) begin
                diff_cnt  <= '0;
                clk_level <= clk_sync[1];
            end else begin
                diff_cnt <= diff_cnt + 1'b1;
            end
        end
    end

    assign line.clk_fall   = clk_fall;
    assign line.clk_level  = clk_level;
    assign line.data_level = data_sync[1];

    // Downstream blocks count one bit per strobe
    a_single_fall : assert property (
        @(posedge clock_i) disable iff (reset_i) clk_fall |=> !clk_fall
    );

endmodule

//--- design/ps2_line_if.sv
// Filtered PS/2 line events and open-drain pull requests between blocks

`timescale 1ns/1ps

interface ps2_line_if;

    // From the filter
    logic clk_fall;
    logic clk_level;
    logic data_level;

    // From the transmitter, go straight to the pad enables
    logic clk_pull;
    logic data_pull;

    modport filter (
        output clk_fall,
        output clk_level,
        output data_level
    );

    modport receiver (
        input  clk_fall,
        input  clk_level,
        input  data_level
    );

    modport transmitter (
        input  clk_fall,
        input  clk_level,
        input  data_level,
        output clk_pull,
        output data_pull
    );

endinterface

//--- design/ps2_pkg.sv
// Shared data types of the PS/2 host port

`include "ps2_consts.svh"

package ps2_pkg;

    // One byte on the wire, sent LSB first
    typedef logic [`PS2_DATA_BITS-1:0] ps2_byte_t;

    // Position inside an 11-bit frame
    // Needs room for one count past the last bit
    typedef logic [3:0] ps2_bit_count_t;

endpackage

//--- design/ps2_consts.svh
// PS/2 host port timing constants and frame widths

`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

// ------------------------------------------------------------
// Line filter
// ------------------------------------------------------------

// Consecutive equal clock samples before the filtered level flips
`define PS2_FILTER_CYCLES 8

// ------------------------------------------------------------
// Host to device request
// ------------------------------------------------------------

// Clock inhibit before a send, stands in for the 100 us of the bus
`define PS2_INHIBIT_CYCLES 200

// ------------------------------------------------------------
// Frame layout
// ------------------------------------------------------------

// Start, data, parity and stop
`define PS2_DATA_BITS  8
`define PS2_FRAME_BITS 11

`endif
